/* design/mx_accumulator.sv */
`timescale 1ns/1ps
module mx_accumulator #(
  parameter int DIM = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  mx_pkg::mx_exp_t in_data,
  output logic out_valid,
  input  logic out_ready,
  output mx_pkg::mx_sum_t out_data
);
  import mx_pkg::*;

  localparam int CNT_W = $clog2(DIM + 1);

  logic [CNT_W-1:0] cnt;
  logic [SUM_MAN_W-1:0] acc_man;
  logic [EXP_W-1:0] acc_exp;
  logic [SUM_MAN_W-1:0] ext;
  logic signed [EXP_W:0] in_e;
  logic signed [EXP_W:0] acc_e;
  logic signed [EXP_W:0] diff;
  logic [SUM_MAN_W-1:0] next_man;
  logic [EXP_W-1:0] next_exp;
  logic last;

  // Hold off input until the finished sum is taken
  assign in_ready = !out_valid;
  assign last = (cnt == CNT_W'(DIM - 1));

  always_comb begin
    ext = SUM_MAN_W'(in_data.man) << SUM_UF;
    in_e = $signed(in_data.exp);
    acc_e = $signed(acc_exp);
    diff = in_e - acc_e;
    if (cnt == '0) begin
      next_man = ext;
      next_exp = in_data.exp;
    end else if (diff > 0) begin
      // New element dominates, align the running sum
      next_man = (acc_man >> diff) + ext;
      next_exp = in_data.exp;
    end else begin
      next_man = acc_man + (ext >> (-diff));
      next_exp = acc_exp;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (in_valid && in_ready) begin
        if (last) begin
          cnt <= '0;
          out_valid <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      acc_man <= next_man;
      acc_exp <= next_exp;
      if (last) begin
        out_data.man <= next_man;
        out_data.exp <= next_exp;
      end
    end
  end

endmodule

/* design/mx_cast.sv */
`timescale 1ns/1ps
module mx_cast (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  mx_pkg::mx_quot_t in_data,
  output logic out_valid,
  input  logic out_ready,
  output mx_pkg::mx_in_t out_data
);
  import mx_pkg::*;

  localparam int EXP_MAX = 2 ** (EXP_W - 1) - 1;
  localparam int EXP_MIN = -(2 ** (EXP_W - 1));

  logic [Q_MAN_W-1:0] norm;
  logic [MAN_W-1:0] rnd;
  logic signed [EXP_W:0] q_exp;
  int pos;
  int e_calc;
  mx_in_t res;

  function automatic int lead_one(input logic [Q_MAN_W-1:0] v);
    int p;
    p = 0;
    for (int i = 0; i < Q_MAN_W; i++) begin
      if (v[i]) begin
        p = i;
      end
    end
    return p;
  endfunction

  assign in_ready = !out_valid || out_ready;

  always_comb begin
    q_exp = $signed(in_data.exp);
    pos = lead_one(in_data.man);
    // Leading one to the top, then keep MAN_W-1 bits
    norm = in_data.man << (Q_MAN_W - 1 - pos);
    rnd = {1'b0, norm[Q_MAN_W-1 -: MAN_W-1]} + norm[Q_MAN_W-MAN_W];
    e_calc = q_exp - DIV_UF + pos;
    if (rnd[MAN_W-1]) begin
      // Rounded up to 2.0, renormalize
      res.man = MAN_W'(1) << (MAN_W - 2);
      e_calc = e_calc + 1;
    end else begin
      res.man = rnd;
    end
    if (in_data.man == '0) begin
      res.man = '0;
      e_calc = 0;
    end
    if (e_calc > EXP_MAX) begin
      res.exp = EXP_W'(EXP_MAX);
    end else if (e_calc < EXP_MIN) begin
      res.exp = EXP_W'(EXP_MIN);
    end else begin
      res.exp = EXP_W'(e_calc);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= res;
    end
  end

endmodule

/* design/mx_circular.sv */
`timescale 1ns/1ps
module mx_circular #(
  parameter int DIM = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  mx_pkg::mx_sum_t in_data,
  output logic out_valid,
  input  logic out_ready,
  output mx_pkg::mx_sum_t out_data
);
  import mx_pkg::*;

  localparam int CNT_W = $clog2(DIM + 1);

  logic full;
  logic [CNT_W-1:0] replay;
  mx_sum_t held;

  assign in_ready = !full;
  assign out_valid = full;
  assign out_data = held;

  // One sum per vector, given once to every element
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
      replay <= '0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
      replay <= '0;
    end else if (out_valid && out_ready) begin
      if (replay == CNT_W'(DIM - 1)) begin
        full <= 1'b0;
        replay <= '0;
      end else begin
        replay <= replay + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      held <= in_data;
    end
  end

endmodule

/* design/mx_div.sv */
`timescale 1ns/1ps
module mx_div (
  input  logic clk,
  input  logic rst,
  input  logic dvd_valid,
  output logic dvd_ready,
  input  mx_pkg::mx_exp_t dvd_data,
  input  logic dvs_valid,
  output logic dvs_ready,
  input  mx_pkg::mx_sum_t dvs_data,
  output logic out_valid,
  input  logic out_ready,
  output mx_pkg::mx_quot_t out_data
);
  import mx_pkg::*;

  localparam int REM_W = SUM_MAN_W + 1;
  localparam int STEP_W = $clog2(Q_MAN_W + 1);

  logic busy;
  logic idle;
  logic join_fire;
  logic [STEP_W-1:0] step;
  logic [REM_W-1:0] rem;
  logic [REM_W-1:0] trial;
  logic [Q_MAN_W-1:0] quo;
  logic [SUM_MAN_W-1:0] dvs_man;
  logic signed [EXP_W:0] q_exp;

  // Join, both sides consumed together
  assign idle = !busy && !out_valid;
  assign dvd_ready = idle && dvs_valid;
  assign dvs_ready = idle && dvd_valid;
  assign join_fire = idle && dvd_valid && dvs_valid;

  // Shift next dividend bit into the partial remainder
  assign trial = {rem[REM_W-2:0], quo[Q_MAN_W-1]};

  assign out_data.man = quo;
  assign out_data.exp = q_exp;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      step <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (join_fire) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        if (step == STEP_W'(Q_MAN_W)) begin
          busy <= 1'b0;
          out_valid <= 1'b1;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  // Restoring division, one quotient bit per cycle
  always_ff @(posedge clk) begin
    if (join_fire) begin
      rem <= '0;
      quo <= Q_MAN_W'(dvd_data.man) << (SUM_UF + DIV_UF);
      dvs_man <= dvs_data.man;
      q_exp <= $signed({dvd_data.exp[EXP_W-1], dvd_data.exp})
             - $signed({dvs_data.exp[EXP_W-1], dvs_data.exp});
    end else if (busy && step != STEP_W'(Q_MAN_W)) begin
      if (trial >= {1'b0, dvs_man}) begin
        rem <= trial - {1'b0, dvs_man};
        quo <= {quo[Q_MAN_W-2:0], 1'b1};
      end else begin
        rem <= trial;
        quo <= {quo[Q_MAN_W-2:0], 1'b0};
      end
    end
  end

  // Sum of exponentials always holds at least 1.0
  a_divisor_nonzero: assert property (@(posedge clk) disable iff (rst)
    join_fire |-> dvs_data.man != '0);

endmodule

/* design/mx_exp.sv */
`timescale 1ns/1ps
module mx_exp (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  mx_pkg::mx_in_t in_data,
  output logic out_valid,
  input  logic out_ready,
  output mx_pkg::mx_exp_t out_data
);
  import mx_pkg::*;

  localparam int FX_W = 32;
  // Larger shifts saturate the exponent anyway
  localparam int MAX_LSH = EXP_W + 2;
  localparam int EXP_MAX = 2 ** (EXP_W - 1) - 1;
  localparam int EXP_MIN = -(2 ** (EXP_W - 1));

  logic signed [FX_W-1:0] man_ext;
  logic signed [FX_W-1:0] fx;
  logic signed [FX_W-1:0] int_part;
  logic signed [EXP_W-1:0] exp_s;
  mx_exp_t res;

  assign in_ready = !out_valid || out_ready;

  // Fixed point x with R_W fraction bits, floor on right shift
  always_comb begin
    man_ext = FX_W'($signed(in_data.man));
    exp_s = $signed(in_data.exp);
    if (exp_s >= 0) begin
      if (exp_s > MAX_LSH) begin
        fx = man_ext <<< MAX_LSH;
      end else begin
        fx = man_ext <<< exp_s;
      end
    end else begin
      fx = man_ext >>> (-exp_s);
    end
    int_part = fx >>> R_W;

    // Mitchell: 2^(i+f) ~ (1+f) * 2^i
    if (int_part > EXP_MAX) begin
      res.exp = EXP_W'(EXP_MAX);
      res.man = MAN_W'({1'b1, {R_W{1'b1}}});
    end else if (int_part < EXP_MIN) begin
      res.exp = EXP_W'(EXP_MIN);
      res.man = MAN_W'({1'b1, {R_W{1'b0}}});
    end else begin
      res.exp = EXP_W'(int_part);
      res.man = MAN_W'({1'b1, fx[R_W-1:0]});
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= res;
    end
  end

  // Held beat must not change under back-pressure
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* design/mx_fifo.sv */
`timescale 1ns/1ps
module mx_fifo #(
  parameter int DEPTH = 2,
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic wr_en;
  logic rd_en;

  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr];
  // Full FIFO still takes a beat when one leaves on the same edge
  assign in_ready = (count != CW'(DEPTH)) || out_ready;
  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // A write with no read never lifts the count past the depth
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    wr_en && !rd_en |=> count != '0 && count <= CW'(DEPTH));

  // A read with no write never takes the count below zero
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    rd_en && !wr_en |=> count < CW'(DEPTH));

endmodule

/* design/mx_fork.sv */
`timescale 1ns/1ps
module mx_fork #(
  parameter int DIM = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  mx_pkg::mx_exp_t in_data,
  output logic sum_valid,
  input  logic sum_ready,
  output mx_pkg::mx_exp_t sum_data,
  output logic keep_valid,
  input  logic keep_ready,
  output mx_pkg::mx_exp_t keep_data
);
  import mx_pkg::*;

  logic fifo_in_valid;
  logic fifo_in_ready;

  // Both branches take the element on the same edge
  assign in_ready = sum_ready && fifo_in_ready;
  assign sum_valid = in_valid && fifo_in_ready;
  assign fifo_in_valid = in_valid && sum_ready;
  assign sum_data = in_data;

  // Two vectors deep so the next one can start summing
  mx_fifo #(
    .DEPTH(2 * DIM),
    .T(mx_exp_t)
  ) keep_fifo (
    .clk(clk),
    .rst(rst),
    .in_valid(fifo_in_valid),
    .in_ready(fifo_in_ready),
    .in_data(in_data),
    .out_valid(keep_valid),
    .out_ready(keep_ready),
    .out_data(keep_data)
  );

endmodule

/* design/mx_pkg.sv */
package mx_pkg;

  // Element format, two's complement mantissa with 2 fraction bits
  localparam int MAN_W = 4;
  localparam int EXP_W = 8;

  // Fraction bits kept by the exponential
  localparam int R_W = 2;

  // Extra fraction bits in the sum and in the quotient
  localparam int SUM_UF = 4;
  localparam int DIV_UF = 4;

  // Room for DIM up to 16
  localparam int SUM_MAN_W = MAN_W + SUM_UF + 4;
  localparam int Q_MAN_W = 12;

  // Input and output element
  typedef struct packed {
    logic [MAN_W-1:0] man;
    logic [EXP_W-1:0] exp;
  } mx_in_t;

  // Exponential, unsigned mantissa 1.00 to 1.11
  typedef struct packed {
    logic [MAN_W-1:0] man;
    logic [EXP_W-1:0] exp;
  } mx_exp_t;

  typedef struct packed {
    logic [SUM_MAN_W-1:0] man;
    logic [EXP_W-1:0] exp;
  } mx_sum_t;

  // Quotient, DIV_UF fraction bits, exponent one bit wider
  typedef struct packed {
    logic [Q_MAN_W-1:0] man;
    logic [EXP_W:0] exp;
  } mx_quot_t;

endpackage

/* design/mx_softmax.sv */
`timescale 1ns/1ps
module mx_softmax #(
  parameter int DIM = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  mx_pkg::mx_in_t in_data,
  output logic out_valid,
  input  logic out_ready,
  output mx_pkg::mx_in_t out_data
);
  import mx_pkg::*;

  // Exponential output
  logic exp_valid;
  logic exp_ready;
  mx_exp_t exp_data;

  // Straight branch to the sum
  logic sum_valid;
  logic sum_ready;
  mx_exp_t sum_data;

  // Buffered copy, used as dividend
  logic keep_valid;
  logic keep_ready;
  mx_exp_t keep_data;

  logic acc_valid;
  logic acc_ready;
  mx_sum_t acc_data;

  logic circ_valid;
  logic circ_ready;
  mx_sum_t circ_data;

  logic div_valid;
  logic div_ready;
  mx_quot_t div_data;

  logic q_valid;
  logic q_ready;
  mx_quot_t q_data;

  mx_exp exp_inst (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .out_valid(exp_valid), .out_ready(exp_ready), .out_data(exp_data)
  );

  mx_fork #(.DIM(DIM)) fork_inst (
    .clk(clk), .rst(rst),
    .in_valid(exp_valid), .in_ready(exp_ready), .in_data(exp_data),
    .sum_valid(sum_valid), .sum_ready(sum_ready), .sum_data(sum_data),
    .keep_valid(keep_valid), .keep_ready(keep_ready), .keep_data(keep_data)
  );

  mx_accumulator #(.DIM(DIM)) acc_inst (
    .clk(clk), .rst(rst),
    .in_valid(sum_valid), .in_ready(sum_ready), .in_data(sum_data),
    .out_valid(acc_valid), .out_ready(acc_ready), .out_data(acc_data)
  );

  mx_circular #(.DIM(DIM)) circ_inst (
    .clk(clk), .rst(rst),
    .in_valid(acc_valid), .in_ready(acc_ready), .in_data(acc_data),
    .out_valid(circ_valid), .out_ready(circ_ready), .out_data(circ_data)
  );

  mx_div div_inst (
    .clk(clk), .rst(rst),
    .dvd_valid(keep_valid), .dvd_ready(keep_ready), .dvd_data(keep_data),
    .dvs_valid(circ_valid), .dvs_ready(circ_ready), .dvs_data(circ_data),
    .out_valid(div_valid), .out_ready(div_ready), .out_data(div_data)
  );

  mx_fifo #(.DEPTH(2), .T(mx_quot_t)) quot_fifo (
    .clk(clk), .rst(rst),
    .in_valid(div_valid), .in_ready(div_ready), .in_data(div_data),
    .out_valid(q_valid), .out_ready(q_ready), .out_data(q_data)
  );

  mx_cast cast_inst (
    .clk(clk), .rst(rst),
    .in_valid(q_valid), .in_ready(q_ready), .in_data(q_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
  );

endmodule

/* sim/tb_mx_softmax.sv */
`timescale 1ns/1ps
module tb_mx_softmax;
  import mx_pkg::*;

  localparam int DIM = 8;
  localparam int TIMEOUT = 2000;

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  mx_in_t in_data;
  logic out_valid;
  logic out_ready;
  mx_in_t out_data;

  mx_in_t stim [3*DIM];
  mx_in_t resp [3*DIM];
  logic [31:0] seed;
  int errors;
  int checks;
  bit timed_out;

  mx_softmax #(.DIM(DIM)) u_dut (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Mantissa has 2 fraction bits
  function automatic real value_of(input mx_in_t v);
    int e;
    e = $signed(v.exp);
    return $itor($signed(v.man)) / 4.0 * (2.0 ** e);
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR %0t ns %s: got %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
  endtask

  task automatic drive_inputs(input int count);
    int i;
    int idle;
    i = 0;
    idle = 0;
    while (i < count && !timed_out) begin
      @(negedge clk);
      in_valid = 1'b1;
      in_data = stim[i];
      // in_ready comes from registers only, stable here
      if (in_ready) begin
        i++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          report_timeout("in_ready");
        end
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic gather_outputs(input int count, input bit pressure);
    int n;
    int idle;
    n = 0;
    idle = 0;
    while (n < count && !timed_out) begin
      @(negedge clk);
      if (pressure) begin
        seed = xorshift32(seed);
        out_ready = seed[0];
      end else begin
        out_ready = 1'b1;
      end
      if (out_valid && out_ready) begin
        resp[n] = out_data;
        n++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          report_timeout("out_valid");
        end
      end
    end
    out_ready = 1'b1;
  endtask

  task automatic run_vector(input int count, input bit pressure);
    fork
      drive_inputs(count);
      gather_outputs(count, pressure);
    join
  endtask

  task automatic check_reset();
    repeat (4) begin
      @(negedge clk);
      compare("out_valid", out_valid, 1'b0);
      compare("in_ready", in_ready, 1'b1);
    end
  endtask

  // Equal inputs share the sum evenly, 1/8 = 1.00 x 2^-3
  task automatic uniform_vector();
    mx_in_t v;
    int e;
    for (int k = 0; k < 4 && !timed_out; k++) begin
      seed = xorshift32(seed);
      v.man = seed[3:0];
      e = int'(seed[10:8]) % 5 - 2;
      v.exp = EXP_W'(e);
      for (int i = 0; i < DIM; i++) begin
        stim[i] = v;
      end
      run_vector(DIM, 1'b0);
      for (int i = 0; i < DIM; i++) begin
        compare("out_data.man", resp[i].man, 4'b0100);
        compare("out_data.exp", resp[i].exp, 8'hfd);
      end
    end
  endtask

  task automatic dominant_element();
    real vd;
    for (int i = 0; i < DIM; i++) begin
      // -1.0 x 2^2
      stim[i] = '{man: 4'b1100, exp: 8'd2};
    end
    stim[3] = '{man: 4'b0100, exp: 8'd2};
    run_vector(DIM, 1'b0);
    vd = value_of(resp[3]);
    // One output LSB at 1.0 is 0.25
    compare("out_data dominant near 1.0", (vd >= 0.75 && vd <= 1.25), 1'b1);
    for (int i = 0; i < DIM; i++) begin
      if (i != 3) begin
        compare($sformatf("out_data %0d below dominant", i), value_of(resp[i]) < vd, 1'b1);
      end
    end
  endtask

  // Inputs below 1.0 and non-negative, random mantissa and scale
  task automatic input_ordering();
    for (int i = 0; i < DIM; i++) begin
      seed = xorshift32(seed);
      stim[i].man = {1'b0, seed[2:0]};
      stim[i].exp = seed[8] ? 8'hff : 8'hfe;
    end
    run_vector(DIM, 1'b0);
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        if (value_of(stim[i]) > value_of(stim[j])) begin
          compare($sformatf("out_data order %0d over %0d", i, j),
                  value_of(resp[i]) >= value_of(resp[j]), 1'b1);
        end
      end
    end
  endtask

  task automatic streaming_backpressure();
    mx_in_t vec_in [3*DIM];
    mx_in_t ref_out [3*DIM];
    int e;
    for (int i = 0; i < 3 * DIM; i++) begin
      seed = xorshift32(seed);
      vec_in[i].man = seed[3:0];
      e = int'(seed[10:8]) % 5 - 2;
      vec_in[i].exp = EXP_W'(e);
    end
    // Reference results, one vector at a time
    for (int v = 0; v < 3; v++) begin
      for (int i = 0; i < DIM; i++) begin
        stim[i] = vec_in[v*DIM + i];
      end
      run_vector(DIM, 1'b0);
      for (int i = 0; i < DIM; i++) begin
        ref_out[v*DIM + i] = resp[i];
      end
    end
    for (int i = 0; i < 3 * DIM; i++) begin
      stim[i] = vec_in[i];
    end
    run_vector(3 * DIM, 1'b1);
    for (int i = 0; i < 3 * DIM; i++) begin
      compare($sformatf("out_data %0d", i), resp[i], ref_out[i]);
    end
    // Nothing beyond the 24 outputs
    repeat (40) begin
      @(negedge clk);
      compare("out_valid after last output", out_valid, 1'b0);
    end
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b1;
    seed = 32'hf5e7;
    errors = 0;
    checks = 0;
    timed_out = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    check_reset();
    if (!timed_out) uniform_vector();
    if (!timed_out) dominant_element();
    if (!timed_out) input_ordering();
    if (!timed_out) streaming_backpressure();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sources.f */
design/mx_pkg.sv
design/mx_fifo.sv
design/mx_exp.sv
design/mx_fork.sv
design/mx_accumulator.sv
design/mx_circular.sv
design/mx_div.sv
design/mx_cast.sv
design/mx_softmax.sv
sim/tb_mx_softmax.sv
